// File: rtl/dma_cfg.svh
`ifndef DMA_CFG_SVH
`define DMA_CFG_SVH

// Bus and register widths
`define DMA_ADDR_W 32
`define DMA_DATA_W 32
`define DMA_LEN_W 5

// Burst shape, 8 beats of one 32-bit word each
`define DMA_BURST_LEN 7
`define DMA_BEAT_CNT_W 3
`define DMA_BURST_BYTES 32

// Tail bits tested for the 4 KiB interrupt boundary
`define DMA_PAGE_BITS 12

// Register file layout, one strobe bit per register
`define DMA_NUM_REGS 5
`define DMA_REG_SRC 0
`define DMA_REG_DEST 1
`define DMA_REG_TAIL 2
`define DMA_REG_HEAD 3
`define DMA_REG_CTRL 4

// Control and status bits
`define DMA_CTRL_START 0
`define DMA_CTRL_INTR 31

`endif

// File: rtl/dma_pkg.sv
`default_nettype none

`include "dma_cfg.svh"

package dma_pkg;

	// Scalar vectors
	typedef logic [`DMA_ADDR_W-1:0] addr_t;
	typedef logic [`DMA_DATA_W-1:0] data_t;
	typedef logic [`DMA_LEN_W-1:0] burst_len_t;
	typedef logic [`DMA_BEAT_CNT_W-1:0] beat_cnt_t;
	typedef logic [`DMA_NUM_REGS-1:0] reg_sel_t;

	// Software write port, one-hot strobe plus word
	typedef struct packed {
		reg_sel_t strobe;
		data_t data;
	} reg_wr_t;

	// Register file contents as seen by both engines
	typedef struct packed {
		addr_t src_base;
		addr_t dest_base;
		addr_t head_ptr;
		addr_t tail_ptr;
		addr_t ctrl_stat;
	} dma_regs_t;

	// Burst request, shared by read and write buses
	typedef struct packed {
		addr_t addr;
		burst_len_t len;
	} mem_req_t;

	// One-hot FSM encodings
	typedef enum logic [2:0] {
		RD_IDLE = 3'b001,
		RD_REQ = 3'b010,
		RD_DATA = 3'b100
	} rd_state_e;

	typedef enum logic [5:0] {
		WR_IDLE = 6'b000001,
		WR_REQ = 6'b000010,
		WR_FIFO_RD = 6'b000100,
		WR_LOAD = 6'b001000,
		WR_DATA = 6'b010000,
		WR_INTR = 6'b100000
	} wr_state_e;

endpackage

`default_nettype wire

// File: rtl/dma_regs.sv
`timescale 1ns/1ps
`default_nettype none

`include "dma_cfg.svh"

module dma_regs (
	input logic clk,
	input logic rst,
	input dma_pkg::reg_wr_t reg_wr,
	input logic tail_adv,
	input logic intr_set,
	output dma_pkg::dma_regs_t regs,
	output logic intr
);
	import dma_pkg::*;

	// Tail after one finished write burst
	addr_t tail_next;

	assign tail_next = regs.tail_ptr + addr_t'(`DMA_BURST_BYTES);

	//////////////////////////////////////////////////////////////////////
	// Register file
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			regs <= '0;
		end
		else
		begin
			// Plain software registers
			if (reg_wr.strobe[`DMA_REG_SRC])
			begin
				regs.src_base <= reg_wr.data;
			end
			if (reg_wr.strobe[`DMA_REG_DEST])
			begin
				regs.dest_base <= reg_wr.data;
			end
			if (reg_wr.strobe[`DMA_REG_HEAD])
			begin
				regs.head_ptr <= reg_wr.data;
			end
			// Software write beats the engine advance
			if (reg_wr.strobe[`DMA_REG_TAIL])
			begin
				regs.tail_ptr <= reg_wr.data;
			end
			else if (tail_adv)
			begin
				regs.tail_ptr <= tail_next;
			end
			// Interrupt set leaves the other control bits alone
			if (reg_wr.strobe[`DMA_REG_CTRL])
			begin
				regs.ctrl_stat <= reg_wr.data;
			end
			else if (intr_set)
			begin
				regs.ctrl_stat[`DMA_CTRL_INTR] <= 1'b1;
			end
		end
	end

	// Interrupt line straight off the status bit
	assign intr = regs.ctrl_stat[`DMA_CTRL_INTR];

	// Software addresses one register per cycle
	a_strobe_onehot0: assert property (@(posedge clk) disable iff (rst)
		$onehot0(reg_wr.strobe))
		else $error("dma_regs: more than one register strobe set");

endmodule

`default_nettype wire

// File: rtl/dma_read_engine.sv
`timescale 1ns/1ps
`default_nettype none

`include "dma_cfg.svh"

module dma_read_engine (
	input logic clk,
	input logic rst,
	input dma_pkg::dma_regs_t regs,
	input logic wr_idle,
	input logic fifo_full,
	output dma_pkg::mem_req_t rd_req,
	output logic rd_req_valid,
	input logic rd_req_ready,
	input dma_pkg::data_t rd_rdata,
	input logic rd_valid,
	input logic rd_last,
	output logic rd_ready,
	output logic fifo_wen,
	output dma_pkg::data_t fifo_wdata
);
	import dma_pkg::*;

	rd_state_e state_q;
	rd_state_e state_d;
	// Byte offset from source base, one burst per step
	addr_t rd_offset;
	logic start_ok;
	logic req_fire;
	logic last_fire;

	// Start only with the writer parked and work pending
	assign start_ok = wr_idle & regs.ctrl_stat[`DMA_CTRL_START]
		& (regs.head_ptr != regs.tail_ptr);
	assign req_fire = rd_req_valid & rd_req_ready;
	assign last_fire = rd_valid & rd_ready & rd_last;

	//////////////////////////////////////////////////////////////////////
	// Bus side
	//////////////////////////////////////////////////////////////////////

	assign rd_req.addr = regs.src_base + rd_offset;
	assign rd_req.len = burst_len_t'(`DMA_BURST_LEN);
	// No new request once the FIFO holds a burst
	assign rd_req_valid = (state_q == RD_REQ) & ~fifo_full;
	assign rd_ready = (state_q == RD_DATA);

	// Accepted beats go straight into the FIFO
	assign fifo_wen = rd_valid & rd_ready;
	assign fifo_wdata = rd_rdata;

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			rd_offset <= '0;
		end
		else if (last_fire)
		begin
			rd_offset <= rd_offset + addr_t'(`DMA_BURST_BYTES);
		end
	end

	//////////////////////////////////////////////////////////////////////
	// FSM
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			state_q <= RD_IDLE;
		end
		else
		begin
			state_q <= state_d;
		end
	end

	always_comb
	begin
		state_d = state_q;
		case (state_q)
			RD_IDLE:
				if (start_ok)
				begin
					state_d = RD_REQ;
				end
			// Full FIFO hands over to the writer
			RD_REQ:
				if (fifo_full)
				begin
					state_d = RD_IDLE;
				end
				else if (req_fire)
				begin
					state_d = RD_DATA;
				end
			RD_DATA:
				if (last_fire)
				begin
					state_d = RD_REQ;
				end
			default:
				state_d = RD_IDLE;
		endcase
	end

	a_state_onehot: assert property (@(posedge clk) disable iff (rst)
		$onehot(state_q))
		else $error("dma_read_engine: state not one-hot");

endmodule

`default_nettype wire

// File: rtl/dma_write_engine.sv
`timescale 1ns/1ps
`default_nettype none

`include "dma_cfg.svh"

module dma_write_engine (
	input logic clk,
	input logic rst,
	input dma_pkg::dma_regs_t regs,
	input logic fifo_full,
	input logic fifo_empty,
	input dma_pkg::data_t fifo_rdata,
	output logic fifo_rden,
	output dma_pkg::mem_req_t wr_req,
	output logic wr_req_valid,
	input logic wr_req_ready,
	output dma_pkg::data_t wr_data,
	output logic wr_valid,
	output logic wr_last,
	input logic wr_ready,
	output logic tail_adv,
	output logic intr_set,
	output logic wr_idle
);
	import dma_pkg::*;

	wr_state_e state_q;
	wr_state_e state_d;
	// Beat index within the current burst
	beat_cnt_t beat_q;
	// Word captured from the FIFO, held through stalls
	data_t data_q;
	logic start_ok;
	logic page_hit;
	logic req_fire;
	logic beat_fire;

	// Writer kicks off once the reader has filled the FIFO
	assign start_ok = fifo_full & regs.ctrl_stat[`DMA_CTRL_START]
		& (regs.head_ptr != regs.tail_ptr);
	// Tail sits on a 4 KiB boundary
	assign page_hit = (regs.tail_ptr[`DMA_PAGE_BITS-1:0] == '0);
	assign req_fire = wr_req_valid & wr_req_ready;
	assign beat_fire = wr_valid & wr_ready;

	//////////////////////////////////////////////////////////////////////
	// Bus and FIFO side
	//////////////////////////////////////////////////////////////////////

	assign wr_req.addr = regs.dest_base + regs.tail_ptr;
	assign wr_req.len = burst_len_t'(`DMA_BURST_LEN);
	assign wr_req_valid = (state_q == WR_REQ) & ~fifo_empty;

	// One FIFO pop per beat, data back a cycle later
	assign fifo_rden = (state_q == WR_FIFO_RD);

	assign wr_data = data_q;
	assign wr_valid = (state_q == WR_DATA);
	assign wr_last = wr_valid & (beat_q == beat_cnt_t'(`DMA_BURST_LEN));

	// Engine strobes into the register file
	assign tail_adv = beat_fire & wr_last;
	assign intr_set = (state_q == WR_INTR);
	assign wr_idle = (state_q == WR_IDLE);

	// Capture in WR_LOAD when fifo_rdata is valid
	always_ff @(posedge clk)
	begin
		if (state_q == WR_LOAD)
		begin
			data_q <= fifo_rdata;
		end
	end

	// Wraps to zero after the eighth beat
	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			beat_q <= '0;
		end
		else if (beat_fire)
		begin
			beat_q <= beat_q + beat_cnt_t'(1);
		end
	end

	//////////////////////////////////////////////////////////////////////
	// FSM
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			state_q <= WR_IDLE;
		end
		else
		begin
			state_q <= state_d;
		end
	end

	always_comb
	begin
		state_d = state_q;
		case (state_q)
			WR_IDLE:
				if (start_ok)
				begin
					state_d = WR_REQ;
				end
			// Drained FIFO ends the pass, maybe with an interrupt
			WR_REQ:
				if (fifo_empty)
				begin
					state_d = page_hit ? WR_INTR : WR_IDLE;
				end
				else if (req_fire)
				begin
					state_d = WR_FIFO_RD;
				end
			WR_FIFO_RD:
				state_d = WR_LOAD;
			WR_LOAD:
				state_d = WR_DATA;
			// Hold the word until wr_ready
			WR_DATA:
				if (beat_fire)
				begin
					state_d = wr_last ? WR_REQ : WR_FIFO_RD;
				end
			WR_INTR:
				state_d = WR_IDLE;
			default:
				state_d = WR_IDLE;
		endcase
	end

	// A granted burst always finds its words in the FIFO
	a_no_empty_pop: assert property (@(posedge clk) disable iff (rst)
		fifo_rden |-> !fifo_empty)
		else $error("dma_write_engine: FIFO read while empty");

	a_state_onehot: assert property (@(posedge clk) disable iff (rst)
		$onehot(state_q))
		else $error("dma_write_engine: state not one-hot");

endmodule

`default_nettype wire

// File: rtl/dma_engine_core.sv
`timescale 1ns/1ps
`default_nettype none

module dma_engine_core (
	input logic clk,
	input logic rst,
	// Software register port
	input dma_pkg::reg_wr_t reg_wr,
	output dma_pkg::dma_regs_t regs,
	output logic intr,
	// Read bus
	output dma_pkg::mem_req_t rd_req,
	output logic rd_req_valid,
	input logic rd_req_ready,
	input dma_pkg::data_t rd_rdata,
	input logic rd_valid,
	input logic rd_last,
	output logic rd_ready,
	// Write bus
	output dma_pkg::mem_req_t wr_req,
	output logic wr_req_valid,
	input logic wr_req_ready,
	output dma_pkg::data_t wr_data,
	output logic wr_valid,
	output logic wr_last,
	input logic wr_ready,
	// External FIFO
	output logic fifo_wen,
	output dma_pkg::data_t fifo_wdata,
	output logic fifo_rden,
	input dma_pkg::data_t fifo_rdata,
	input logic fifo_empty,
	input logic fifo_full
);

	// Engine strobes back into the register file
	logic tail_adv;
	logic intr_set;
	// Reader waits on this
	logic wr_idle;

	//////////////////////////////////////////////////////////////////////
	// Registers
	//////////////////////////////////////////////////////////////////////

	dma_regs i_dma_regs (
		.clk(clk),
		.rst(rst),
		.reg_wr(reg_wr),
		.tail_adv(tail_adv),
		.intr_set(intr_set),
		.regs(regs),
		.intr(intr)
	);

	//////////////////////////////////////////////////////////////////////
	// Engines
	//////////////////////////////////////////////////////////////////////

	dma_read_engine i_dma_read_engine (
		.clk(clk),
		.rst(rst),
		.regs(regs),
		.wr_idle(wr_idle),
		.fifo_full(fifo_full),
		.rd_req(rd_req),
		.rd_req_valid(rd_req_valid),
		.rd_req_ready(rd_req_ready),
		.rd_rdata(rd_rdata),
		.rd_valid(rd_valid),
		.rd_last(rd_last),
		.rd_ready(rd_ready),
		.fifo_wen(fifo_wen),
		.fifo_wdata(fifo_wdata)
	);

	dma_write_engine i_dma_write_engine (
		.clk(clk),
		.rst(rst),
		.regs(regs),
		.fifo_full(fifo_full),
		.fifo_empty(fifo_empty),
		.fifo_rdata(fifo_rdata),
		.fifo_rden(fifo_rden),
		.wr_req(wr_req),
		.wr_req_valid(wr_req_valid),
		.wr_req_ready(wr_req_ready),
		.wr_data(wr_data),
		.wr_valid(wr_valid),
		.wr_last(wr_last),
		.wr_ready(wr_ready),
		.tail_adv(tail_adv),
		.intr_set(intr_set),
		.wr_idle(wr_idle)
	);

endmodule

`default_nettype wire

// File: dv/dma_engine_tb.sv
`timescale 1ns/1ps
`default_nettype none

module dma_engine_tb;
	import dma_pkg::*;

	localparam int CLK_HALF = 20;
	localparam int BURST_BEATS = 8;
	localparam int BURST_BYTES = 32;
	localparam int LEN_CODE = 7;
	localparam int FIFO_DEPTH = 8;
	// Last beat, WR_REQ, WR_INTR, then the status bit is up
	localparam int SETTLE_CYCLES = 3;
	localparam int unsigned RAND_SEED = 32'h5ea7_14b5;
	localparam TRACE_PATH = "dv/dma_trace.txt";

	logic clk;
	logic rst;
	reg_wr_t reg_wr;
	dma_regs_t regs;
	logic intr;
	mem_req_t rd_req;
	logic rd_req_valid;
	logic rd_req_ready;
	data_t rd_rdata;
	logic rd_valid;
	logic rd_last;
	logic rd_ready;
	mem_req_t wr_req;
	logic wr_req_valid;
	logic wr_req_ready;
	data_t wr_data;
	logic wr_valid;
	logic wr_last;
	logic wr_ready;
	logic fifo_wen;
	data_t fifo_wdata;
	logic fifo_rden;
	data_t fifo_rdata;
	logic fifo_empty;
	logic fifo_full;

	// Source memory by byte address
	data_t mem [addr_t];
	data_t fifo_q [$];
	// Expected write bursts from the trace
	addr_t exp_addr_q [$];
	data_t exp_data_q [$];

	// Shadows of what software wrote
	addr_t src_shadow;
	addr_t dest_shadow;
	addr_t tail_exp;
	int rd_bursts;
	int wr_beat;
	logic tail_check_due;

	// Handshakes seen at the last rising edge
	logic rd_req_hit;
	logic rd_beat_hit;
	logic rd_end_hit;
	logic wr_req_hit;
	logic wr_beat_hit;
	logic fifo_push;
	logic fifo_pop;
	data_t push_word;
	addr_t rd_req_addr;

	// Read bus model state
	logic rd_open;
	addr_t rd_base;
	int rd_beat;

	// Write bus model state
	logic rng_seeded;

	int cycle_cnt;
	int cycle_limit;

	dma_engine_core i_dma_engine_core (
		.clk(clk), .rst(rst), .reg_wr(reg_wr), .regs(regs), .intr(intr),
		.rd_req(rd_req), .rd_req_valid(rd_req_valid), .rd_req_ready(rd_req_ready),
		.rd_rdata(rd_rdata), .rd_valid(rd_valid), .rd_last(rd_last), .rd_ready(rd_ready),
		.wr_req(wr_req), .wr_req_valid(wr_req_valid), .wr_req_ready(wr_req_ready),
		.wr_data(wr_data), .wr_valid(wr_valid), .wr_last(wr_last), .wr_ready(wr_ready),
		.fifo_wen(fifo_wen), .fifo_wdata(fifo_wdata), .fifo_rden(fifo_rden),
		.fifo_rdata(fifo_rdata), .fifo_empty(fifo_empty), .fifo_full(fifo_full)
	);

	always
	begin
		#(CLK_HALF) clk = ~clk;
	end

	//////////////////////////////////////////////////////////////////////
	// Failure reporting and small helpers
	//////////////////////////////////////////////////////////////////////

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("Simulation finished: FAIL");
		$fatal(1, "Run stopped at the first failure");
	endtask

	task automatic value_error(input string msg);
		abort_run($sformatf("** Error at %0t ns: %s", $time, msg));
	endtask

	task automatic expect_fields(input int got, input int want, input string line);
		if (got != want)
			abort_run($sformatf("Malformed trace line: %s", line));
	endtask

	// Index order follows the register map of src, dest, tail, head and control
	function automatic addr_t field_of(input dma_regs_t r, input int idx);
		case (idx)
			0: return r.src_base;
			1: return r.dest_base;
			2: return r.tail_ptr;
			3: return r.head_ptr;
			default: return r.ctrl_stat;
		endcase
	endfunction

	// One strobe cycle, then the value must be on regs
	task automatic write_reg(input int idx, input data_t word);
		@(negedge clk);
		reg_wr.strobe = reg_sel_t'(1 << idx);
		reg_wr.data = word;
		if (idx == 0)
			src_shadow = word;
		if (idx == 1)
			dest_shadow = word;
		if (idx == 2)
			tail_exp = word;
		@(negedge clk);
		reg_wr = '0;
		assert (field_of(regs, idx) == word)
			else value_error($sformatf("register %0d reads %h, wrote %h",
				idx, field_of(regs, idx), word));
	endtask

	// Traffic done once every expected beat is gone and tail met head
	task automatic wait_drained();
		while (exp_addr_q.size() != 0 || exp_data_q.size() != 0
			|| regs.tail_ptr != regs.head_ptr)
			@(negedge clk);
		repeat (SETTLE_CYCLES) @(negedge clk);
	endtask

	//////////////////////////////////////////////////////////////////////
	// Bus checks on values held across the rising edge
	//////////////////////////////////////////////////////////////////////

	always @(posedge clk)
	begin
		if (rst)
		begin
			rd_req_hit = 1'b0;
			rd_beat_hit = 1'b0;
			rd_end_hit = 1'b0;
			wr_req_hit = 1'b0;
			wr_beat_hit = 1'b0;
			fifo_push = 1'b0;
			fifo_pop = 1'b0;
		end
		else
		begin
			rd_req_hit = rd_req_valid && rd_req_ready;
			rd_beat_hit = rd_valid && rd_ready;
			rd_end_hit = rd_beat_hit && rd_last;
			wr_req_hit = wr_req_valid && wr_req_ready;
			wr_beat_hit = wr_valid && wr_ready;
			fifo_push = fifo_wen;
			fifo_pop = fifo_rden;
			push_word = fifo_wdata;
			rd_req_addr = rd_req.addr;
			// Tail moved one cycle after the 8th beat
			if (tail_check_due)
			begin
				assert (regs.tail_ptr == tail_exp)
					else value_error($sformatf("tail is %h, expected %h",
						regs.tail_ptr, tail_exp));
				tail_check_due = 1'b0;
			end
			// FIFO write path mirrors the accepted read beat
			assert (fifo_wen == rd_beat_hit && (!fifo_wen || fifo_wdata == rd_rdata))
				else value_error("fifo_wen or fifo_wdata does not follow the read beat");
			if (rd_req_hit)
			begin
				assert (rd_req.addr == src_shadow + addr_t'(BURST_BYTES * rd_bursts)
					&& rd_req.len == LEN_CODE)
					else value_error($sformatf("read request %h len %0d, expected %h",
						rd_req.addr, rd_req.len,
						src_shadow + addr_t'(BURST_BYTES * rd_bursts)));
			end
			if (rd_end_hit)
				rd_bursts++;
			if (wr_req_hit)
			begin
				if (exp_addr_q.size() == 0)
					abort_run("Write request arrived with no burst left in the trace");
				else
				begin
					assert (wr_req.addr == exp_addr_q[0]
						&& wr_req.addr == dest_shadow + tail_exp
						&& wr_req.len == LEN_CODE)
						else value_error($sformatf("write request %h len %0d, expected %h",
							wr_req.addr, wr_req.len, exp_addr_q[0]));
					void'(exp_addr_q.pop_front());
					wr_beat = 0;
				end
			end
			if (wr_beat_hit)
			begin
				if (exp_data_q.size() == 0)
					abort_run("Write beat arrived with no data left in the trace");
				else
				begin
					assert (wr_data == exp_data_q[0])
						else value_error($sformatf("write beat %0d is %h, expected %h",
							wr_beat, wr_data, exp_data_q[0]));
					assert (wr_last == (wr_beat == BURST_BEATS - 1))
						else value_error($sformatf("wr_last is %0b on beat %0d",
							wr_last, wr_beat));
					void'(exp_data_q.pop_front());
					if (wr_beat == BURST_BEATS - 1)
					begin
						tail_exp = tail_exp + addr_t'(BURST_BYTES);
						tail_check_due = 1'b1;
					end
					wr_beat++;
				end
			end
		end
	end

	//////////////////////////////////////////////////////////////////////
	// FIFO and bus models driven on the falling edge
	//////////////////////////////////////////////////////////////////////

	always @(negedge clk)
	begin
		// Popped word shows up one cycle after fifo_rden
		if (fifo_pop)
		begin
			if (fifo_q.size() == 0)
				abort_run("FIFO model was read while empty");
			else
				fifo_rdata = fifo_q.pop_front();
		end
		if (fifo_push)
		begin
			if (fifo_q.size() == FIFO_DEPTH)
				abort_run("FIFO model was written while full");
			else
				fifo_q.push_back(push_word);
		end
		fifo_full = (fifo_q.size() == FIFO_DEPTH);
		fifo_empty = (fifo_q.size() == 0);

		// Read bus keeps one request open at a time
		if (rd_req_hit)
		begin
			rd_open = 1'b1;
			rd_base = rd_req_addr;
			rd_beat = 0;
		end
		else if (rd_end_hit)
			rd_open = 1'b0;
		else if (rd_beat_hit)
			rd_beat++;
		rd_req_ready = !rd_open;
		rd_valid = rd_open;
		rd_last = rd_open && (rd_beat == BURST_BEATS - 1);
		rd_rdata = '0;
		if (rd_open)
		begin
			if (!mem.exists(rd_base + addr_t'(4 * rd_beat)))
				abort_run("Read burst touched an address with no trace data");
			else
				rd_rdata = mem[rd_base + addr_t'(4 * rd_beat)];
		end

		// Write bus applies random back-pressure on data only
		if (!rng_seeded)
		begin
			// Seed once, ahead of the first draw of this process
			void'($urandom(RAND_SEED));
			rng_seeded = 1'b1;
		end
		wr_req_ready = 1'b1;
		wr_ready = ($urandom % 4) != 0;
	end

	always @(posedge clk)
	begin
		cycle_cnt++;
		if (cycle_limit > 0 && cycle_cnt > cycle_limit)
			abort_run($sformatf("Timeout after %0d cycles, traffic never drained", cycle_cnt));
	end

	//////////////////////////////////////////////////////////////////////
	// Trace sequencer
	//////////////////////////////////////////////////////////////////////

	initial
	begin : run_trace
		string line;
		byte tag;
		int fd;
		int fields;
		int idx;
		int burst_cnt;
		addr_t addr;
		data_t word;
		data_t words [BURST_BEATS];

		clk = 1'b0;
		rst = 1'b1;
		reg_wr = '0;
		rd_req_ready = 1'b0;
		rd_rdata = '0;
		rd_valid = 1'b0;
		rd_last = 1'b0;
		wr_req_ready = 1'b0;
		wr_ready = 1'b0;
		fifo_rdata = '0;
		fifo_empty = 1'b1;
		fifo_full = 1'b0;
		rd_open = 1'b0;
		rd_beat = 0;
		rd_bursts = 0;
		wr_beat = 0;
		tail_check_due = 1'b0;
		src_shadow = '0;
		dest_shadow = '0;
		tail_exp = '0;
		rng_seeded = 1'b0;
		cycle_cnt = 0;
		cycle_limit = 0;

		// First pass sizes the timeout from the traced bursts
		burst_cnt = 0;
		fd = $fopen(TRACE_PATH, "r");
		if (fd == 0)
			abort_run("Cannot open trace file dv/dma_trace.txt");
		while ($fgets(line, fd))
		begin
			if (line.len() > 0 && line.getc(0) == "E")
				burst_cnt++;
		end
		$fclose(fd);
		cycle_limit = 40 * BURST_BEATS * burst_cnt + 200;

		repeat (3) @(posedge clk);
		@(negedge clk);
		assert (regs == '0 && !rd_req_valid && !rd_ready && !wr_req_valid && !wr_valid
			&& !wr_last && !fifo_wen && !fifo_rden && !intr)
			else value_error("outputs not at their reset values");
		rst = 1'b0;

		fd = $fopen(TRACE_PATH, "r");
		while ($fgets(line, fd))
		begin
			tag = line.getc(0);
			case (tag)
				"R":
				begin
					fields = $sscanf(line, "R %d %h", idx, word);
					expect_fields(fields, 2, line);
					write_reg(idx, word);
				end
				"M":
				begin
					fields = $sscanf(line, "M %h %h %h %h %h %h %h %h %h", addr,
						words[0], words[1], words[2], words[3],
						words[4], words[5], words[6], words[7]);
					expect_fields(fields, 9, line);
					for (int i = 0; i < BURST_BEATS; i++)
					begin
						mem[addr + addr_t'(4 * i)] = words[i];
					end
				end
				"E":
				begin
					fields = $sscanf(line, "E %h %h %h %h %h %h %h %h %h", addr,
						words[0], words[1], words[2], words[3],
						words[4], words[5], words[6], words[7]);
					expect_fields(fields, 9, line);
					exp_addr_q.push_back(addr);
					for (int i = 0; i < BURST_BEATS; i++)
					begin
						exp_data_q.push_back(words[i]);
					end
				end
				"I":
				begin
					fields = $sscanf(line, "I %d", idx);
					expect_fields(fields, 1, line);
					wait_drained();
					assert (intr == idx[0])
						else value_error($sformatf("intr is %0b, trace expects %0d",
							intr, idx));
				end
				default:
				begin
					// Comment or blank line
				end
			endcase
		end
		$fclose(fd);

		if (exp_addr_q.size() == 0 && exp_data_q.size() == 0)
		begin
			$display("Simulation finished: PASS");
			$finish;
		end
		else
			abort_run("Trace ended with expected write traffic still outstanding");
	end

endmodule

`default_nettype wire

// File: dv/dma_trace.txt
# R <reg 0 src 1 dest 2 tail 3 head 4 ctrl> <data>   M <byte addr> <8 source words>
# E <write addr> <8 expected words>   I <intr expected once traffic drains>
M 00001000 c0de0000 c0de0001 c0de0002 c0de0003 c0de0004 c0de0005 c0de0006 c0de0007
E 00008fe0 c0de0000 c0de0001 c0de0002 c0de0003 c0de0004 c0de0005 c0de0006 c0de0007
R 0 00001000
R 1 00008000
R 2 00000fe0
R 3 00001000
R 4 00000001
I 1
R 4 00000000
I 0
M 00002020 2a000000 2a000011 2a000022 2a000033 2a000044 2a000055 2a000066 2a000077
M 00002040 2b000000 2b000011 2b000022 2b000033 2b000044 2b000055 2b000066 2b000077
E 00004100 2a000000 2a000011 2a000022 2a000033 2a000044 2a000055 2a000066 2a000077
E 00004120 2b000000 2b000011 2b000022 2b000033 2b000044 2b000055 2b000066 2b000077
R 0 00002000
R 1 00004000
R 2 00000100
R 3 00000140
R 4 00000001
I 0

// File: compile.f
+incdir+rtl
rtl/dma_pkg.sv
rtl/dma_regs.sv
rtl/dma_read_engine.sv
rtl/dma_write_engine.sv
rtl/dma_engine_core.sv
dv/dma_engine_tb.sv

// File: Bender.yml
package:
  name: dma_engine_core

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/dma_pkg.sv
      - rtl/dma_regs.sv
      - rtl/dma_read_engine.sv
      - rtl/dma_write_engine.sv
      - rtl/dma_engine_core.sv
  - target: test
    files:
      - dv/dma_engine_tb.sv
